/* verilog/vga_pkg.sv */
// ********************
// VGA timing constants and pixel-stream types for 800x600 at 60 Hz
// ********************

`default_nettype none

package vga_pkg;

    // ********************
    // Pixel-stream types
    // ********************

    typedef logic [10:0] coord_t;                  // Raster counter value
    typedef logic [11:0] rgb_t;                    // 4 bits each of red, green and blue

    // ********************
    // Horizontal timing in pixel clocks
    // ********************

    localparam coord_t h_visible    = 11'd800;     // Active pixels per line
    localparam coord_t h_sync_start = 11'd840;     // First pixel with hsync high
    localparam coord_t h_sync_end   = 11'd968;     // First pixel after the sync pulse
    localparam coord_t h_total      = 11'd1056;    // Pixels per line including blanking

    // ********************
    // Vertical timing in lines
    // ********************

    // Both sync pulses are active high for this mode, so they idle low

    localparam coord_t v_visible    = 11'd600;     // Active lines per frame
    localparam coord_t v_sync_start = 11'd601;     // First line with vsync high
    localparam coord_t v_sync_end   = 11'd605;     // First line after the sync pulse
    localparam coord_t v_total      = 11'd628;     // Lines per frame including blanking

endpackage

`default_nettype wire

/* verilog/board_pkg.sv */
// ********************
// Board geometry and colours for background and grid
// ********************

`default_nettype none

package board_pkg;

    // ********************
    // Geometry
    // ********************

    localparam int cell_count = 12;                 // Cells along each side of the board
    localparam int cell_size  = 32;                 // Cell pitch in pixels, a power of two

    // The closing line sits one pixel past the last cell
    localparam vga_pkg::coord_t board_span = vga_pkg::coord_t'(cell_count * cell_size + 1);

    localparam vga_pkg::coord_t board_x = 11'd208;  // Default left edge of the board
    localparam vga_pkg::coord_t board_y = 11'd108;  // Default top edge of the board

    localparam vga_pkg::coord_t border_width = 11'd4; // Width of the screen frame

    // ********************
    // Colours
    // ********************

    localparam vga_pkg::rgb_t bg_color     = 12'h363; // Board green
    localparam vga_pkg::rgb_t border_color = 12'hfa0; // Orange screen frame
    localparam vga_pkg::rgb_t line_color   = 12'hfff; // White grid lines

endpackage

`default_nettype wire

/* verilog/vga_if.sv */
// ********************
// One stage of the pixel stream with in and out modports
// ********************

`default_nettype none

interface vga_if;

    vga_pkg::coord_t hcount;   // Horizontal position of this pixel
    vga_pkg::coord_t vcount;   // Vertical position of this pixel
    logic            hsync;
    logic            vsync;
    logic            hblnk;    // High outside the visible columns
    logic            vblnk;    // High outside the visible lines
    vga_pkg::rgb_t   rgb;      // Colour painted so far

    // Driving stage
    modport out (
        output hcount, vcount,
        output hsync, vsync,
        output hblnk, vblnk,
        output rgb
    );

    // Reading stage
    modport in (
        input hcount, vcount,
        input hsync, vsync,
        input hblnk, vblnk,
        input rgb
    );

endinterface

`default_nettype wire

/* verilog/vga_timing.sv */
// ********************
// Raster counters with sync and blank generation
// ********************

`default_nettype none

module vga_timing (
    input  logic clk,
    input  logic rst,
    vga_if.out   out
);

    // ********************
    // Raster position
    // ********************

    vga_pkg::coord_t h_cnt;
    vga_pkg::coord_t v_cnt;

    logic line_end;
    logic frame_end;

    assign line_end  = (h_cnt == vga_pkg::h_total - 1'b1);
    assign frame_end = (v_cnt == vga_pkg::v_total - 1'b1);

    always_ff @(posedge clk) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (line_end) begin
            h_cnt <= '0;                               // Wrap and step to the next line
            if (frame_end) begin
                v_cnt <= '0;                           // Back to the top of the frame
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // ********************
    // Registered stream
    // ********************

    logic hsync_nxt;
    logic vsync_nxt;
    logic hblnk_nxt;
    logic vblnk_nxt;

    always_comb begin
        hsync_nxt = (h_cnt >= vga_pkg::h_sync_start) && (h_cnt < vga_pkg::h_sync_end);
        vsync_nxt = (v_cnt >= vga_pkg::v_sync_start) && (v_cnt < vga_pkg::v_sync_end);
        hblnk_nxt = (h_cnt >= vga_pkg::h_visible);
        vblnk_nxt = (v_cnt >= vga_pkg::v_visible);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out.hcount <= '0;
            out.vcount <= '0;
            out.hsync  <= 1'b0;
            out.vsync  <= 1'b0;
            out.hblnk  <= 1'b0;
            out.vblnk  <= 1'b0;
        end else begin
            out.hcount <= h_cnt;                       // One cycle behind the counters
            out.vcount <= v_cnt;
            out.hsync  <= hsync_nxt;
            out.vsync  <= vsync_nxt;
            out.hblnk  <= hblnk_nxt;
            out.vblnk  <= vblnk_nxt;
        end
    end

    assign out.rgb = '0;                               // Later stages paint every pixel

endmodule

`default_nettype wire

/* verilog/draw_background.sv */
// ********************
// Background fill with a frame along the screen edge
// ********************

`default_nettype none

module draw_background (
    input  logic clk,
    input  logic rst,
    vga_if.in    in,
    vga_if.out   out
);

    vga_pkg::rgb_t rgb_nxt;
    logic          on_border;

    // The frame covers the outermost columns and lines of the visible area
    always_comb begin
        on_border = (in.hcount < board_pkg::border_width)
                 || (in.hcount >= vga_pkg::h_visible - board_pkg::border_width)
                 || (in.vcount < board_pkg::border_width)
                 || (in.vcount >= vga_pkg::v_visible - board_pkg::border_width);
    end

    always_comb begin
        if (on_border) begin
            rgb_nxt = board_pkg::border_color;
        end else begin
            rgb_nxt = board_pkg::bg_color;
        end
    end

    // ********************
    // Stage register
    // ********************

    always_ff @(posedge clk) begin
        if (rst) begin
            out.hcount <= '0;
            out.vcount <= '0;
            out.hsync  <= 1'b0;
            out.vsync  <= 1'b0;
            out.hblnk  <= 1'b0;
            out.vblnk  <= 1'b0;
            out.rgb    <= '0;
        end else begin
            out.hcount <= in.hcount;
            out.vcount <= in.vcount;
            out.hsync  <= in.hsync;
            out.vsync  <= in.vsync;
            out.hblnk  <= in.hblnk;
            out.vblnk  <= in.vblnk;
            out.rgb    <= rgb_nxt;                 // Replaces whatever came in
        end
    end

endmodule

`default_nettype wire

/* verilog/draw_grid.sv */
// ********************
// White grid lines of the playing board
// ********************

`default_nettype none

module draw_grid #(
    parameter vga_pkg::coord_t x_pos = board_pkg::board_x,   // Left edge of the board
    parameter vga_pkg::coord_t y_pos = board_pkg::board_y    // Top edge of the board
) (
    input  logic clk,
    input  logic rst,
    vga_if.in    in,
    vga_if.out   out
);

    localparam int cell_bits = $clog2(board_pkg::cell_size);

    // ********************
    // Board-relative position
    // ********************

    vga_pkg::coord_t dx;
    vga_pkg::coord_t dy;

    // Left of or above the origin the difference wraps to a large value
    assign dx = in.hcount - x_pos;
    assign dy = in.vcount - y_pos;

    logic on_board;
    logic on_line;

    always_comb begin
        on_board = (dx < board_pkg::board_span) && (dy < board_pkg::board_span);
        on_line  = (dx[cell_bits-1:0] == '0) || (dy[cell_bits-1:0] == '0); // Cell boundaries
    end

    vga_pkg::rgb_t rgb_nxt;

    always_comb begin
        if (on_board && on_line) begin
            rgb_nxt = board_pkg::line_color;
        end else begin
            rgb_nxt = in.rgb;                      // Cell interior and off-board pixels
        end
    end

    // ********************
    // Stage register
    // ********************

    always_ff @(posedge clk) begin
        if (rst) begin
            out.hcount <= '0;
            out.vcount <= '0;
            out.hsync  <= 1'b0;
            out.vsync  <= 1'b0;
            out.hblnk  <= 1'b0;
            out.vblnk  <= 1'b0;
            out.rgb    <= '0;
        end else begin
            out.hcount <= in.hcount;
            out.vcount <= in.vcount;
            out.hsync  <= in.hsync;
            out.vsync  <= in.vsync;
            out.hblnk  <= in.hblnk;
            out.vblnk  <= in.vblnk;
            out.rgb    <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

/* verilog/vga_out.sv */
// ********************
// Output register with blanking and colour channel split
// ********************

`default_nettype none

module vga_out (
    input  logic       clk,
    input  logic       rst,
    vga_if.in          in,
    output logic       hsync,
    output logic       vsync,
    output logic [3:0] r,
    output logic [3:0] g,
    output logic [3:0] b
);

    vga_pkg::rgb_t rgb_nxt;

    // The monitor expects black during both blanking intervals
    assign rgb_nxt = (in.hblnk || in.vblnk) ? '0 : in.rgb;

    always_ff @(posedge clk) begin
        if (rst) begin
            hsync <= 1'b0;
            vsync <= 1'b0;
            r     <= '0;
            g     <= '0;
            b     <= '0;
        end else begin
            hsync <= in.hsync;                     // Same delay as the colour
            vsync <= in.vsync;
            r     <= rgb_nxt[11:8];
            g     <= rgb_nxt[7:4];
            b     <= rgb_nxt[3:0];
        end
    end

endmodule

`default_nettype wire

/* verilog/game_display.sv */
// ********************
// Top level of the board display pipeline
// ********************

`default_nettype none

module game_display (
    input  logic       clk,
    input  logic       rst,
    output logic       hsync,
    output logic       vsync,
    output logic [3:0] r,
    output logic [3:0] g,
    output logic [3:0] b
);

    // ********************
    // Stage buses
    // ********************

    vga_if timing_bus ();   // Raster position and sync
    vga_if bg_bus ();       // After background fill
    vga_if grid_bus ();     // After grid overlay

    // ********************
    // Pipeline
    // ********************

    vga_timing u_vga_timing (
        .clk (clk),
        .rst (rst),
        .out (timing_bus)
    );

    draw_background u_draw_background (
        .clk (clk),
        .rst (rst),
        .in  (timing_bus),
        .out (bg_bus)
    );

    draw_grid u_draw_grid (
        .clk (clk),
        .rst (rst),
        .in  (bg_bus),
        .out (grid_bus)
    );

    vga_out u_vga_out (
        .clk   (clk),
        .rst   (rst),
        .in    (grid_bus),
        .hsync (hsync),
        .vsync (vsync),
        .r     (r),
        .g     (g),
        .b     (b)
    );

endmodule

`default_nettype wire

/* dv/clk_gen.sv */
// ********************
// Testbench clock and synchronous reset source
// ********************

`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                    // 100 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;                               // Released on a rising edge
    end

endmodule

`default_nettype wire

/* dv/game_display_checker.sv */
// ********************
// Concurrent assertions on the sync and colour outputs
// ********************

`default_nettype none

module game_display_checker (
    input logic       clk,
    input logic       rst,
    input logic       hsync,
    input logic       vsync,
    input logic [3:0] r,
    input logic [3:0] g,
    input logic [3:0] b
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ht       = int'(vga_pkg::h_total);
    localparam int low_min  = ht - 128;            // Low time between two sync pulses
    localparam int rise_gap = int'(vga_pkg::h_total - vga_pkg::h_sync_start) - 1;

    int   low_run;
    int   since_rise;
    logic hsync_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            low_run    <= low_min;
            since_rise <= ht;
            hsync_d    <= 1'b0;
        end else begin
            hsync_d <= hsync;
            if (hsync) begin
                low_run <= 0;
            end else if (low_run < low_min) begin
                low_run <= low_run + 1;
            end
            if (hsync && !hsync_d) begin
                since_rise <= 0;                   // Line restarts counting here
            end else if (since_rise < ht) begin
                since_rise <= since_rise + 1;
            end
        end
    end

    // vsync moves at the start of a line, a fixed distance after the hsync rise
    hsync_low_time: assert property (@(posedge clk) disable iff (rst)
        $rose(hsync) |-> low_run >= low_min) else $error("hsync pulse came too early");
    blank_on_sync: assert property (@(posedge clk) disable iff (rst)
        (hsync || vsync) |-> ({r, g, b} == 12'h000)) else $error("colour during sync");
    quiet_in_reset: assert property (@(posedge clk)
        rst |=> ({hsync, vsync, r, g, b} == 14'h0)) else $error("outputs active in reset");
    vsync_on_line: assert property (@(posedge clk) disable iff (rst)
        $changed(vsync) |-> since_rise == rise_gap) else $error("vsync moved mid line");

endmodule

`default_nettype wire

/* dv/game_display_tb.sv */
// ********************
// Testbench with raster tracking, reference colours and sync measurement
// ********************

`default_nettype none

module game_display_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ht = int'(vga_pkg::h_total);
    localparam int vt = int'(vga_pkg::v_total);
    localparam int hv = int'(vga_pkg::h_visible);
    localparam int vv = int'(vga_pkg::v_visible);
    localparam int frame_len = ht * vt;
    localparam int bx = int'(board_pkg::board_x);
    localparam int by = int'(board_pkg::board_y);
    localparam int span = int'(board_pkg::board_span);

    logic clk;
    logic rst;
    logic hsync;
    logic vsync;
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;

    clk_gen u_clk_gen (.clk(clk), .rst(rst));

    game_display dut (.clk(clk), .rst(rst), .hsync(hsync), .vsync(vsync), .r(r), .g(g), .b(b));

    bind game_display game_display_checker u_checker (.*);

    string names [5] = '{"reset_state", "sync_timing", "blanking", "background", "grid_lines"};
    int checks [5];
    int errs [5];
    int timeouts = 0;
    int cyc = 0;
    logic [31:0] lfsr = 32'h8b3a_0728;
    bit spot [0:frame_len-1];                      // Second-frame spot check positions

    // ********************
    // Reference model and helpers
    // ********************

    function automatic logic [11:0] expected_rgb(input int h, input int v);
        int dx;
        int dy;
        dx = h - bx;
        dy = v - by;
        if (h >= hv || v >= vv) return 12'h000;    // Blanking
        if (dx >= 0 && dx < span && dy >= 0 && dy < span && (dx % 32 == 0 || dy % 32 == 0))
            return board_pkg::line_color;
        if (h < 4 || h >= hv - 4 || v < 4 || v >= vv - 4) return board_pkg::border_color;
        return board_pkg::bg_color;
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1); // Galois step
        end
        return v;
    endfunction

    task automatic check(input int t, input int e, input int a);
        checks[t]++;
        if (e != a) begin
            errs[t]++;
            if (errs[t] <= 5) $display("FAIL %s: expected 0x%0h, actual 0x%0h", names[t], e, a);
        end
    endtask

    // Counts negedges while the chosen sync stays at a level
    task automatic measure(input bit use_v, input logic level, input int limit, output int n);
        n = 0;
        while ((use_v ? vsync : hsync) == level && n < limit) begin
            n++;
            @(negedge clk);
        end
        if (n >= limit) begin
            timeouts++;
            $display("Timeout: %s stayed at %0d for %0d cycles", use_v ? "vsync" : "hsync",
                     level, limit);
        end
    endtask

    always @(posedge clk) begin
        if (rst) cyc <= 0;
        else cyc <= cyc + 1;                       // Pixel 0 reaches the pins at count 4
    end

    // ********************
    // Pixel comparison over two frames
    // ********************

    int idx;
    int pos;
    int h;
    int v;
    int exp_c;
    int act_c;

    always @(negedge clk) begin
        if (!rst && cyc >= 4 && cyc - 4 < 2 * frame_len) begin
            idx = cyc - 4;
            pos = idx % frame_len;
            h = pos % ht;
            v = pos / ht;
            exp_c = int'(expected_rgb(h, v));
            act_c = int'({r, g, b});
            if (h >= hv || v >= vv) check(2, exp_c, act_c);
            else if (exp_c == int'(board_pkg::line_color)) check(4, exp_c, act_c);
            else if (v >= by && v < by + span && (h == bx - 1 || h == bx + span))
                check(4, exp_c, act_c);            // Just outside the board edge
            else check(3, exp_c, act_c);
            if (idx >= frame_len && spot[pos]) check(4, exp_c, act_c);
        end
    end

    // ********************
    // Test sequence
    // ********************

    initial begin
        int n_hi;
        int n_lo;
        int wait_n;
        int total;
        int failed;
        for (int i = 0; i < 200; i++) begin
            n_hi = take_bits(11) % ht;
            n_lo = take_bits(10) % vt;
            spot[n_lo * ht + n_hi] = 1'b1;
        end
        @(negedge clk);
        wait_n = 0;
        while (cyc < 4 && wait_n < 100) begin      // Pipeline still filling
            if (cyc < 3) begin
                check(0, 0, int'({r, g, b}));      // Count 3 shows the cleared position unblanked
            end
            check(0, 0, int'({hsync, vsync}));
            wait_n++;
            @(negedge clk);
        end
        if (wait_n >= 100) begin
            timeouts++;
            $display("Timeout: reset was never released");
        end
        $display("test %s done: %0d errors", names[0], errs[0]);
        for (int i = 0; i < 2 && timeouts == 0; i++) begin
            measure(1'b0, 1'b0, 2 * ht, n_lo);
            check(1, 4 + int'(vga_pkg::h_sync_start) + i * ht, cyc); // Aligned with the pixels
            measure(1'b0, 1'b1, ht, n_hi);
            measure(1'b0, 1'b0, ht, n_lo);
            check(1, 128, n_hi);
            check(1, ht, n_hi + n_lo);
        end
        for (int i = 0; i < 2 && timeouts == 0; i++) begin
            measure(1'b1, 1'b0, 2 * frame_len, n_lo);
            check(1, 4 + int'(vga_pkg::v_sync_start) * ht + i * frame_len, cyc);
            measure(1'b1, 1'b1, frame_len, n_hi);
            measure(1'b1, 1'b0, frame_len, n_lo);
            check(1, 4 * ht, n_hi);
            check(1, frame_len, n_hi + n_lo);
        end
        $display("test %s done: %0d errors", names[1], errs[1]);
        wait_n = 0;
        while (cyc - 4 < 2 * frame_len && wait_n < 3 * frame_len) begin
            wait_n++;
            @(negedge clk);
        end
        if (wait_n >= 3 * frame_len) begin
            timeouts++;
            $display("Timeout: the two compared frames never completed");
        end
        for (int t = 2; t < 5; t++) begin
            $display("test %s done: %0d checks, %0d errors", names[t], checks[t], errs[t]);
        end
        total = timeouts;
        failed = 0;
        for (int t = 0; t < 5; t++) begin
            total += errs[t];
            if (errs[t] != 0) failed++;
        end
        $display("summary: 5 tests, %0d failed, %0d errors, %0d timeouts", failed, total, timeouts);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
verilog/vga_pkg.sv
verilog/board_pkg.sv
verilog/vga_if.sv
verilog/vga_timing.sv
verilog/draw_background.sv
verilog/draw_grid.sv
verilog/vga_out.sv
verilog/game_display.sv
dv/clk_gen.sv
dv/game_display_checker.sv
dv/game_display_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the display testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f filelist.f --top-module game_display_tb \
    -o game_display_sim \
    && ./obj_dir/game_display_sim 2>&1 | tee sim.log \
    || { echo "Build or simulation aborted"; exit 1; }
grep -q "Errors found" sim.log && { echo "Simulation failed"; exit 1; } \
    || echo "Simulation passed"
